// File: filelist.f
+incdir+verilog
verilog/rx_dsp_pkg.sv
verilog/setting_reg.sv
verilog/decim_strobe_gen.sv
verilog/rx_chain.sv
verilog/rx_source_select.sv
verilog/rx_frame_fifo.sv
verilog/rx_dsp_top.sv
test/rx_dsp_assert.sv
test/rx_dsp_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the RX DSP testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module rx_dsp_tb -f filelist.f -o Vrx_dsp_tb
./obj_dir/Vrx_dsp_tb 2>&1 | tee sim.log
if grep -q "PASS: all tests" sim.log
then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// File: test/rx_dsp_assert.sv
`timescale 1ns/1ps

module rx_dsp_assert
(
   input logic clk64,
   input logic rx_dsp_reset,
   input logic i_clear_status,
   input logic o_have_pkt_rdy,
   input logic o_rx_overrun
);

   // Status outputs come out of reset inactive
   a_idle_after_reset: assert property (@(posedge clk64)
      rx_dsp_reset |=> (!o_have_pkt_rdy && !o_rx_overrun))
      else $error("status outputs active after reset");

   // Overrun is sticky until a clear strobe
   a_overrun_sticky: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      (!$past(rx_dsp_reset) && $fell(o_rx_overrun)) |-> $past(i_clear_status))
      else $error("overrun flag fell without a clear");

endmodule

bind rx_dsp_top rx_dsp_assert rx_dsp_assert_inst
(
   .clk64          (clk64),
   .rx_dsp_reset   (rx_dsp_reset),
   .i_clear_status (i_clear_status),
   .o_have_pkt_rdy (o_have_pkt_rdy),
   .o_rx_overrun   (o_rx_overrun)
);

// File: test/rx_dsp_tb.sv
`timescale 1ns/1ps
`include "rx_dsp_defs.svh"

module rx_dsp_tb;

   logic                      clk64 = 1'b0;
   logic                      rx_dsp_reset;
   rx_dsp_pkg::settings_bus_t i_settings;
   rx_dsp_pkg::adc_sample_t   i_rx_a_a;
   rx_dsp_pkg::adc_sample_t   i_rx_b_a;
   rx_dsp_pkg::adc_sample_t   i_rx_a_b;
   rx_dsp_pkg::adc_sample_t   i_rx_b_b;
   logic                      i_rd = 1'b0;
   logic                      i_clear_status;
   rx_dsp_pkg::rx_frame_t     o_frame;
   logic                      o_have_pkt_rdy;
   logic                      o_rx_overrun;

   // Model state, written by the main process on rising edges only
   logic        pop_en;
   logic        cnt_mode;
   int          rate;
   int          discard;
   int          old_left;
   logic [15:0] cnt_model;
   logic [15:0] old_cnt;
   int          frames_seen;
   int          errors;
   integer      seed;

   always #2 clk64 = ~clk64;

   rx_dsp_top rx_dsp_top_inst (.*);

   task automatic abort_run();
      errors = errors + 1;
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t ns: %s got 0x%04h, expected 0x%04h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic timeout_error(input string what);
      $display("error at %0t ns: timed out waiting for %s", $time, what);
      abort_run();
   endtask

   // Each window sums n copies of the sign-extended sample, kept to 16 bits
   function automatic rx_dsp_pkg::rx_frame_t expected_frame(input logic mode, input int n,
                                                            input logic [15:0] count);
      rx_dsp_pkg::rx_frame_t f;
      int len;
      len = (n == 0) ? 1 : n;
      f.ch0 = mode ? count : 16'(len * int'(i_rx_a_a));
      f.ch1 = mode ? count + 16'd1 : 16'(len * int'(i_rx_b_a));
      f.ch2 = 16'(len * int'(i_rx_a_b));
      f.ch3 = 16'(len * int'(i_rx_b_b));
      return f;
   endfunction

   // Frames stored before a restart come first and continue the old count
   task automatic compare_frame(input rx_dsp_pkg::rx_frame_t got);
      rx_dsp_pkg::rx_frame_t exp;
      logic check_all;
      check_all = 1'b1;
      if (old_left > 0)
      begin
         exp = expected_frame(cnt_mode, rate, old_cnt);
         old_cnt = old_cnt + 16'd2;
         old_left = old_left - 1;
      end
      else
      begin
         exp = expected_frame(cnt_mode, rate, cnt_model);
         cnt_model = cnt_model + 16'd2;
         check_all = (discard == 0);
         discard = 0;
      end
      // The counter words are exact even in a partial first window
      if (cnt_mode || check_all)
      begin
         check_value("ch0", got.ch0, exp.ch0);
         check_value("ch1", got.ch1, exp.ch1);
      end
      if (check_all)
      begin
         check_value("ch2", got.ch2, exp.ch2);
         check_value("ch3", got.ch3, exp.ch3);
      end
      frames_seen = frames_seen + 1;
   endtask

   // Compare process, pops the head whenever a frame is ready
   always @(negedge clk64)
   begin
      if (pop_en && o_have_pkt_rdy)
      begin
         compare_frame(o_frame);
         i_rd = 1'b1;
      end
      else
      begin
         i_rd = 1'b0;
      end
   end

   task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
      @(negedge clk64);
      i_settings.strobe = 1'b1;
      i_settings.addr   = addr;
      i_settings.data   = data;
      @(negedge clk64);
      i_settings.strobe = 1'b0;
   endtask

   task automatic wait_frames(input int target, input int limit);
      int t;
      t = 0;
      while (frames_seen < target)
      begin
         @(posedge clk64);
         t = t + 1;
         if (t > limit)
         begin
            timeout_error("frames from the FIFO");
         end
      end
   endtask

   task automatic wait_overrun(input int limit);
      int t;
      t = 0;
      while (o_rx_overrun !== 1'b1)
      begin
         @(negedge clk64);
         t = t + 1;
         if (t > limit)
         begin
            timeout_error("the overrun flag");
         end
      end
   endtask

   // Four idle cycles in a row mean nothing is left in flight
   task automatic wait_quiet(input int limit);
      int quiet;
      int t;
      quiet = 0;
      t = 0;
      while (quiet < 4)
      begin
         @(negedge clk64);
         quiet = o_have_pkt_rdy ? 0 : quiet + 1;
         t = t + 1;
         if (t > limit)
         begin
            timeout_error("the FIFO to drain");
         end
      end
   endtask

   task automatic clear_overrun();
      @(negedge clk64);
      i_clear_status = 1'b1;
      @(negedge clk64);
      i_clear_status = 1'b0;
      check_value("overrun after clear", 16'(o_rx_overrun), 16'd0);
   endtask

   task automatic start_rx(input logic mode, input int n, input logic pop);
      write_reg(`FR_RX_MODE, 32'd0);
      wait_quiet(200);
      i_rx_a_a = 12'($random(seed));
      i_rx_b_a = 12'($random(seed));
      i_rx_a_b = 12'($random(seed));
      i_rx_b_b = 12'($random(seed));
      @(posedge clk64);
      cnt_mode    = mode;
      rate        = n;
      cnt_model   = 16'd0;
      discard     = 1;
      old_left    = 0;
      frames_seen = 0;
      pop_en      = pop;
      write_reg(`FR_DECIM_RATE, n);
      write_reg(`FR_RX_MODE, {30'd0, mode, 1'b1});
   endtask

   initial
   begin
      int k;
      seed = 32'h4464_7ab8;
      rx_dsp_reset = 1'b1;
      i_settings = '0;
      i_clear_status = 1'b0;
      {i_rx_a_a, i_rx_b_a, i_rx_a_b, i_rx_b_b} = '0;
      pop_en = 1'b0;
      cnt_mode = 1'b0;
      rate = 1;
      discard = 0;
      old_left = 0;
      cnt_model = 16'd0;
      old_cnt = 16'd0;
      frames_seen = 0;
      errors = 0;
      repeat (16) @(posedge clk64);
      @(negedge clk64);
      rx_dsp_reset = 1'b0;

      // Idle after reset, and nothing appears while receive is off
      check_value("have_pkt_rdy after reset", 16'(o_have_pkt_rdy), 16'd0);
      check_value("overrun after reset", 16'(o_rx_overrun), 16'd0);
      write_reg(`FR_DECIM_RATE, 32'd2);
      for (k = 0; k < 40; k = k + 1)
      begin
         @(negedge clk64);
         check_value("have_pkt_rdy while disabled", 16'(o_have_pkt_rdy), 16'd0);
      end

      start_rx(1'b0, 1, 1'b1);
      wait_frames(6, 400);
      start_rx(1'b0, 4, 1'b1);
      wait_frames(6, 400);
      start_rx(1'b0, 2 + ($unsigned($random(seed)) % 15), 1'b1);
      wait_frames(6, 400);
      start_rx(1'b1, 3, 1'b1);
      wait_frames(8, 400);

      // Fill the FIFO past its depth, then drain it in order
      start_rx(1'b1, 1, 1'b0);
      wait_overrun(200);
      write_reg(`FR_RX_MODE, 32'd0);
      repeat (4) @(negedge clk64);
      @(posedge clk64);
      pop_en = 1'b1;
      wait_frames(`RX_FIFO_DEPTH, 100);
      repeat (4) @(negedge clk64);
      check_value("have_pkt_rdy after drain", 16'(o_have_pkt_rdy), 16'd0);
      check_value("overrun before clear", 16'(o_rx_overrun), 16'd1);
      @(posedge clk64);
      check_value("frames after overrun", 16'(frames_seen), 16'(`RX_FIFO_DEPTH));
      clear_overrun();

      // Restart while full; stored frames survive, counter starts again
      start_rx(1'b1, 4, 1'b1);
      wait_frames(3, 200);
      @(posedge clk64);
      pop_en = 1'b0;
      wait_overrun(400);
      write_reg(`FR_RX_MODE, 32'd0);
      clear_overrun();
      write_reg(`FR_RX_MODE, 32'd3);
      @(posedge clk64);
      old_cnt     = cnt_model;
      old_left    = `RX_FIFO_DEPTH;
      cnt_model   = 16'd0;
      discard     = 1;
      frames_seen = 0;
      pop_en      = 1'b1;
      wait_frames(`RX_FIFO_DEPTH + 4, 400);
      @(negedge clk64);
      check_value("overrun after restart", 16'(o_rx_overrun), 16'd0);

      if (errors == 0)
      begin
         $display("PASS: all tests");
         $finish;
      end
      else
      begin
         $display("FAIL: see errors above");
         $fatal(1, "errors were found");
      end
   end

endmodule

// File: verilog/decim_strobe_gen.sv
`timescale 1ns/1ps

module decim_strobe_gen
(
   input  logic                    clk64,
   input  logic                    rx_dsp_reset,
   input  logic                    i_enable,
   input  rx_dsp_pkg::decim_rate_t i_decim_rate,
   output logic                    o_strobe
);

   rx_dsp_pkg::decim_rate_t reload;
   rx_dsp_pkg::decim_rate_t count;

   // A rate of zero runs the same as a rate of one
   assign reload = (i_decim_rate == '0) ? '0 : i_decim_rate - 1'b1;

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         count    <= '0;
         o_strobe <= 1'b0;
      end
      else if (!i_enable)
      begin
         // Park at the reload value so the first window is a full N cycles
         count    <= reload;
         o_strobe <= 1'b0;
      end
      else if (count == '0)
      begin
         count    <= reload;
         o_strobe <= 1'b1;
      end
      else
      begin
         count    <= count - 1'b1;
         o_strobe <= 1'b0;
      end
   end

endmodule

// File: verilog/rx_chain.sv
`timescale 1ns/1ps
`include "rx_dsp_defs.svh"

module rx_chain
(
   input  logic                    clk64,
   input  logic                    rx_dsp_reset,
   input  logic                    i_enable,
   input  logic                    i_strobe,
   input  rx_dsp_pkg::adc_sample_t i_adc_i,
   input  rx_dsp_pkg::adc_sample_t i_adc_q,
   output rx_dsp_pkg::iq_sample_t  o_iq,
   output logic                    o_valid
);

   localparam int EXT_W = `SAMPLE_W - `ADC_W;

   rx_dsp_pkg::bb_sample_t acc_i;
   rx_dsp_pkg::bb_sample_t acc_q;
   rx_dsp_pkg::bb_sample_t sum_i;
   rx_dsp_pkg::bb_sample_t sum_q;
   logic                   dump;

   function automatic rx_dsp_pkg::bb_sample_t sign_ext(input rx_dsp_pkg::adc_sample_t s);
      return {{EXT_W{s[`ADC_W-1]}}, s};
   endfunction

   // Running sum including the current sample, wraps modulo 2**SAMPLE_W
   assign sum_i = acc_i + sign_ext(i_adc_i);
   assign sum_q = acc_q + sign_ext(i_adc_q);

   // A strobe left over from the cycle enable dropped is ignored
   assign dump = i_enable && i_strobe;

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || !i_enable)
      begin
         acc_i   <= '0;
         acc_q   <= '0;
         o_valid <= 1'b0;
      end
      else if (dump)
      begin
         acc_i   <= '0;
         acc_q   <= '0;
         o_valid <= 1'b1;
      end
      else
      begin
         acc_i   <= sum_i;
         acc_q   <= sum_q;
         o_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (dump)
      begin
         o_iq.i <= sum_i;
         o_iq.q <= sum_q;
      end
   end

endmodule

// File: verilog/rx_dsp_defs.svh
`ifndef RX_DSP_DEFS_SVH
`define RX_DSP_DEFS_SVH

// Settings bus geometry
`define SET_ADDR_W 7
`define SET_DATA_W 32

// Register map
`define FR_DECIM_RATE 7'd10
`define FR_RX_MODE    7'd11

// Fields of the mode register
`define RX_MODE_W       2
`define RX_MODE_EN_BIT  0
`define RX_MODE_CNT_BIT 1

// Datapath widths
`define ADC_W    12
`define SAMPLE_W 16
`define DECIM_W  8

// Frame FIFO geometry
// Depth is 2**RX_FIFO_AW so the pointers wrap on their own
`define RX_FIFO_DEPTH 8
`define RX_FIFO_AW    3

`endif

// File: verilog/rx_dsp_pkg.sv
`include "rx_dsp_defs.svh"

package rx_dsp_pkg;

   // Raw converter word, two's complement
   typedef logic signed [`ADC_W-1:0] adc_sample_t;

   // Baseband word after decimation
   typedef logic [`SAMPLE_W-1:0] bb_sample_t;

   typedef logic [`DECIM_W-1:0] decim_rate_t;

   // Register write from the control side
   typedef struct packed {
      logic                   strobe;
      logic [`SET_ADDR_W-1:0] addr;
      logic [`SET_DATA_W-1:0] data;
   } settings_bus_t;

   typedef struct packed {
      bb_sample_t i;
      bb_sample_t q;
   } iq_sample_t;

   // One decimated sample set, ch0 in the top word
   typedef struct packed {
      bb_sample_t ch0;
      bb_sample_t ch1;
      bb_sample_t ch2;
      bb_sample_t ch3;
   } rx_frame_t;

   typedef enum logic [1:0] {
      FIFO_EMPTY,
      FIFO_PARTIAL,
      FIFO_FULL
   } fifo_state_t;

endpackage

// File: verilog/rx_dsp_top.sv
`timescale 1ns/1ps
`include "rx_dsp_defs.svh"

module rx_dsp_top
(
   input  logic                      clk64,
   input  logic                      rx_dsp_reset,
   input  rx_dsp_pkg::settings_bus_t i_settings,
   input  rx_dsp_pkg::adc_sample_t   i_rx_a_a,
   input  rx_dsp_pkg::adc_sample_t   i_rx_b_a,
   input  rx_dsp_pkg::adc_sample_t   i_rx_a_b,
   input  rx_dsp_pkg::adc_sample_t   i_rx_b_b,
   input  logic                      i_rd,
   input  logic                      i_clear_status,
   output rx_dsp_pkg::rx_frame_t     o_frame,
   output logic                      o_have_pkt_rdy,
   output logic                      o_rx_overrun
);

   rx_dsp_pkg::decim_rate_t decim_rate;
   logic [`RX_MODE_W-1:0]   rx_mode;
   logic                    decim_strobe;
   rx_dsp_pkg::iq_sample_t  iq_0;
   rx_dsp_pkg::iq_sample_t  iq_1;
   logic                    valid_0;
   rx_dsp_pkg::rx_frame_t   frame;
   logic                    push;

   wire rx_enable    = rx_mode[`RX_MODE_EN_BIT];
   wire counter_mode = rx_mode[`RX_MODE_CNT_BIT];

   setting_reg #(.ADDR(`FR_DECIM_RATE), .WIDTH(`DECIM_W)) sr_decim
   (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_settings   (i_settings),
      .o_value      (decim_rate)
   );

   setting_reg #(.ADDR(`FR_RX_MODE), .WIDTH(`RX_MODE_W)) sr_mode
   (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_settings   (i_settings),
      .o_value      (rx_mode)
   );

   decim_strobe_gen decim_strobe_gen_inst
   (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_enable     (rx_enable),
      .i_decim_rate (decim_rate),
      .o_strobe     (decim_strobe)
   );

   // Chain 0 takes the A side converters, chain 1 the B side
   rx_chain rx_chain_0
   (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_enable     (rx_enable),
      .i_strobe     (decim_strobe),
      .i_adc_i      (i_rx_a_a),
      .i_adc_q      (i_rx_b_a),
      .o_iq         (iq_0),
      .o_valid      (valid_0)
   );

   // Both chains share the strobe so chain 0's valid covers them both
   rx_chain rx_chain_1
   (
      .clk64        (clk64),
      .rx_dsp_reset (rx_dsp_reset),
      .i_enable     (rx_enable),
      .i_strobe     (decim_strobe),
      .i_adc_i      (i_rx_a_b),
      .i_adc_q      (i_rx_b_b),
      .o_iq         (iq_1),
      .o_valid      ()
   );

   rx_source_select rx_source_select_inst
   (
      .clk64          (clk64),
      .rx_dsp_reset   (rx_dsp_reset),
      .i_enable       (rx_enable),
      .i_counter_mode (counter_mode),
      .i_valid        (valid_0),
      .i_iq0          (iq_0),
      .i_iq1          (iq_1),
      .o_frame        (frame),
      .o_push         (push)
   );

   rx_frame_fifo rx_frame_fifo_inst
   (
      .clk64          (clk64),
      .rx_dsp_reset   (rx_dsp_reset),
      .i_push         (push),
      .i_frame        (frame),
      .i_rd           (i_rd),
      .i_clear_status (i_clear_status),
      .o_frame        (o_frame),
      .o_have_pkt_rdy (o_have_pkt_rdy),
      .o_rx_overrun   (o_rx_overrun)
   );

endmodule

// File: verilog/rx_frame_fifo.sv
`timescale 1ns/1ps
`include "rx_dsp_defs.svh"

module rx_frame_fifo
(
   input  logic                  clk64,
   input  logic                  rx_dsp_reset,
   input  logic                  i_push,
   input  rx_dsp_pkg::rx_frame_t i_frame,
   input  logic                  i_rd,
   input  logic                  i_clear_status,
   output rx_dsp_pkg::rx_frame_t o_frame,
   output logic                  o_have_pkt_rdy,
   output logic                  o_rx_overrun
);

   rx_dsp_pkg::rx_frame_t   mem [`RX_FIFO_DEPTH];
   logic [`RX_FIFO_AW-1:0]  wr_ptr;
   logic [`RX_FIFO_AW-1:0]  rd_ptr;
   logic [`RX_FIFO_AW-1:0]  wr_ptr_inc;
   logic [`RX_FIFO_AW-1:0]  rd_ptr_inc;
   rx_dsp_pkg::fifo_state_t state;
   rx_dsp_pkg::fifo_state_t state_nxt;
   logic                    push_ok;
   logic                    pop_ok;
   logic                    drop;

   assign wr_ptr_inc = wr_ptr + 1'b1;
   assign rd_ptr_inc = rd_ptr + 1'b1;

   // When full a simultaneous read frees the slot for the push
   assign pop_ok  = i_rd && (state != rx_dsp_pkg::FIFO_EMPTY);
   assign push_ok = i_push && ((state != rx_dsp_pkg::FIFO_FULL) || i_rd);
   assign drop    = i_push && !push_ok;

   always_comb
   begin
      state_nxt = state;
      if (push_ok && !pop_ok)
      begin
         state_nxt = (wr_ptr_inc == rd_ptr) ? rx_dsp_pkg::FIFO_FULL
                                            : rx_dsp_pkg::FIFO_PARTIAL;
      end
      else if (pop_ok && !push_ok)
      begin
         state_nxt = (rd_ptr_inc == wr_ptr) ? rx_dsp_pkg::FIFO_EMPTY
                                            : rx_dsp_pkg::FIFO_PARTIAL;
      end
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         state        <= rx_dsp_pkg::FIFO_EMPTY;
         o_rx_overrun <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         if (push_ok)
         begin
            wr_ptr <= wr_ptr_inc;
         end
         if (pop_ok)
         begin
            rd_ptr <= rd_ptr_inc;
         end
         // A drop in the same cycle as a clear keeps the flag set
         if (drop)
         begin
            o_rx_overrun <= 1'b1;
         end
         else if (i_clear_status)
         begin
            o_rx_overrun <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk64)
   begin
      if (push_ok)
      begin
         mem[wr_ptr] <= i_frame;
      end
   end

   // Show-ahead read of the head entry
   assign o_frame        = mem[rd_ptr];
   assign o_have_pkt_rdy = (state != rx_dsp_pkg::FIFO_EMPTY);

endmodule

// File: verilog/rx_source_select.sv
`timescale 1ns/1ps
`include "rx_dsp_defs.svh"

module rx_source_select
(
   input  logic                   clk64,
   input  logic                   rx_dsp_reset,
   input  logic                   i_enable,
   input  logic                   i_counter_mode,
   input  logic                   i_valid,
   input  rx_dsp_pkg::iq_sample_t i_iq0,
   input  rx_dsp_pkg::iq_sample_t i_iq1,
   output rx_dsp_pkg::rx_frame_t  o_frame,
   output logic                   o_push
);

   rx_dsp_pkg::bb_sample_t debug_counter;
   logic                   take;

   assign take = i_enable && i_valid;

   // Debug counter steps by two per frame, restarting whenever receive is off
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset || !i_enable)
      begin
         debug_counter <= '0;
         o_push        <= 1'b0;
      end
      else
      begin
         o_push <= i_valid;
         if (i_valid)
         begin
            debug_counter <= debug_counter + `SAMPLE_W'(2);
         end
      end
   end

   // Frame uses the counter value from before this step
   always_ff @(posedge clk64)
   begin
      if (take)
      begin
         if (i_counter_mode)
         begin
            o_frame.ch0 <= debug_counter;
            o_frame.ch1 <= debug_counter + `SAMPLE_W'(1);
         end
         else
         begin
            o_frame.ch0 <= i_iq0.i;
            o_frame.ch1 <= i_iq0.q;
         end
         o_frame.ch2 <= i_iq1.i;
         o_frame.ch3 <= i_iq1.q;
      end
   end

endmodule

// File: verilog/setting_reg.sv
`timescale 1ns/1ps
`include "rx_dsp_defs.svh"

module setting_reg
#(
   parameter logic [`SET_ADDR_W-1:0] ADDR  = '0,
   parameter int                     WIDTH = 32
)
(
   input  logic                      clk64,
   input  logic                      rx_dsp_reset,
   input  rx_dsp_pkg::settings_bus_t i_settings,
   output logic [WIDTH-1:0]          o_value
);

   logic hit;

   // Only writes aimed at this address are taken
   assign hit = i_settings.strobe && (i_settings.addr == ADDR);

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         o_value <= '0;
      end
      else if (hit)
      begin
         // Upper data bits beyond WIDTH are ignored
         o_value <= i_settings.data[WIDTH-1:0];
      end
   end

endmodule
